// File: bench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen
(
    output logic CLK,
    output logic RESET
);

    initial
    begin
        CLK   = 1'b0;
        RESET = 1'b1;
        repeat (4) @(posedge CLK);
        RESET <= 1'b0;
    end

    always #10 CLK = ~CLK;  // 20 ns period

endmodule

// File: bench/eeprom_model.sv
`timescale 1ns/1ps

module eeprom_model
(
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    output logic drv_en,
    output logic drv_val,
    output logic proto_err,
    output int   n_start,
    output int   n_rstart,
    output int   n_stop
);

    typedef enum {m_idle, m_ctrl, m_addr, m_data, m_ctrl_r, m_send, m_end} phase_t;

    logic [7:0]  mem [2048];
    phase_t      ph;
    logic [7:0]  sh;
    logic [10:0] a;
    logic        wr_pend;
    logic        scl_q;
    logic        sda_q;
    int          bcnt;

    task automatic flag(input string what);
        $display("EEPROM model at %0t: %s", $time, what);
        proto_err = 1'b1;
    endtask

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i) ^ 8'h5a;
        drv_en    = 1'b0;
        drv_val   = 1'b1;
        proto_err = 1'b0;
        wr_pend   = 1'b0;
        n_start   = 0;
        n_rstart  = 0;
        n_stop    = 0;
        ph        = m_idle;
        bcnt      = 0;
        wait (RESET === 1'b0);
        scl_q = scl;
        sda_q = sda;
        forever
        begin
            @(scl or sda);
            if (scl && scl_q && sda_q && !sda)
            begin
                // restart comes right after the address byte, its own clock already counted
                if (ph == m_data && bcnt <= 1)
                begin
                    n_rstart++;
                    ph = m_ctrl_r;
                end
                else
                begin
                    if (ph != m_idle)
                        flag("start condition in the middle of a transfer");
                    n_start++;
                    ph = m_ctrl;
                end
                bcnt = 0;
            end
            else if (scl && scl_q && !sda_q && sda)
            begin
                if (ph != m_end)
                    flag("stop condition before the transfer was complete");
                else if (wr_pend)
                    mem[a] = sh;    // write cycle
                n_stop++;
                ph      = m_idle;
                wr_pend = 1'b0;
            end
            else if (scl && !scl_q && ph inside {m_ctrl, m_addr, m_data, m_ctrl_r})
            begin
                sh = {sh[6:0], sda};
                bcnt++;
                if (bcnt == 8)
                begin
                    bcnt = 0;
                    if (ph == m_ctrl || ph == m_ctrl_r)
                    begin
                        if (sh[7:4] != 4'b1010 || sh[0] != (ph == m_ctrl_r))
                            flag("wrong device code or R/W bit in a control byte");
                        a[10:8] = sh[3:1];
                    end
                    case (ph)
                        m_ctrl:
                            ph = m_addr;
                        m_addr:
                        begin
                            a[7:0] = sh;
                            ph     = m_data;
                        end
                        m_data:
                        begin
                            wr_pend = 1'b1;
                            ph      = m_end;
                        end
                        default:
                        begin
                            sh = mem[a];
                            ph = m_send;
                        end
                    endcase
                end
            end
            else if (scl && !scl_q && ph == m_send)
                bcnt++;     // master samples here
            else if (!scl && scl_q && ph == m_send)
            begin
                if (bcnt == 8)
                begin
                    drv_en = 1'b0;
                    ph     = m_end;
                end
                else
                begin
                    drv_en  = 1'b1;
                    drv_val = sh[7];
                    sh      = {sh[6:0], 1'b0};
                end
            end
            scl_q = scl;
            sda_q = sda;
        end
    end

endmodule

// File: bench/tb_eeprom_ctrl.sv
`timescale 1ns/1ps

module tb_eeprom_ctrl;

    localparam int TIMEOUT  = 20000;    // about 50 transactions of at most 200 cycles plus margin
    localparam int ACK_WAIT = 400;

    logic                 CLK;
    logic                 RESET;
    logic                 wr;
    logic                 rd;
    eeprom_pkg::ee_addr_t addr;
    eeprom_pkg::ee_byte_t wdata;
    logic                 ack;
    eeprom_pkg::ee_byte_t rdata;
    logic                 scl;
    logic                 sda_out;
    logic                 sda_oe;
    logic                 sda;
    logic                 mdl_en;
    logic                 mdl_val;
    logic                 proto_err;
    int                   n_start;
    int                   n_rstart;
    int                   n_stop;
    int                   cycles = 0;
    int                   acks = 0;
    eeprom_pkg::ee_byte_t shadow [2048];

    clock_gen u_clk (.CLK(CLK), .RESET(RESET));

    eeprom_ctrl_top u_eeprom_ctrl_top
    (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr), .wdata(wdata),
        .ack(ack), .rdata(rdata), .scl(scl), .sda_out(sda_out), .sda_oe(sda_oe),
        .sda_in(sda)
    );

    eeprom_model u_model
    (
        .RESET(RESET), .scl(scl), .sda(sda), .drv_en(mdl_en), .drv_val(mdl_val),
        .proto_err(proto_err), .n_start(n_start), .n_rstart(n_rstart), .n_stop(n_stop)
    );

    assign sda = sda_oe ? sda_out : (mdl_en ? mdl_val : 1'b1);    // pull-up when released

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_equal(input string name, input int got, input int expected);
        assert (got == expected)
        else report_fail($sformatf("Mismatch at %0t: %s = 0x%0h, expected 0x%0h",
                                   $time, name, got, expected));
    endtask

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (ack)
            acks <= acks + 1;
        assert (cycles < TIMEOUT)
        else report_fail($sformatf("timeout after %0d cycles", TIMEOUT));
        assert (RESET || !proto_err)
        else report_fail("the EEPROM model saw a protocol error on the wires");
    end

    task automatic wait_ack();
        int n;
        n = 0;
        while (!ack && n < ACK_WAIT)
        begin
            @(posedge CLK);
            n++;
        end
        assert (ack) else report_fail("no ack from the controller");
    endtask

    // one strobe, then the start, repeated start and stop counts seen by the model
    task automatic run_xfer(input logic is_read, input eeprom_pkg::ee_addr_t a,
                            input eeprom_pkg::ee_byte_t d);
        int s0;
        int r0;
        int p0;
        s0 = n_start;
        r0 = n_rstart;
        p0 = n_stop;
        @(posedge CLK);
        wr    <= !is_read;
        rd    <= is_read;
        addr  <= a;
        wdata <= d;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
        wait_ack();
        assert (n_start == s0 + 1 && n_stop == p0 + 1 && n_rstart == r0 + int'(is_read))
        else report_fail("wrong order of start, repeated start and stop on the wires");
    endtask

    task automatic write_byte(input eeprom_pkg::ee_addr_t a, input eeprom_pkg::ee_byte_t d);
        run_xfer(1'b0, a, d);
        shadow[a] = d;
    endtask

    task automatic read_check(input eeprom_pkg::ee_addr_t a,
                              input eeprom_pkg::ee_byte_t expected);
        run_xfer(1'b1, a, '0);
        check_equal("rdata", int'(rdata), int'(expected));
    endtask

    task automatic idle_after_reset();
        check_equal("ack", int'(ack), 0);
        check_equal("sda_oe", int'(sda_oe), 0);
        repeat (20)
        begin
            @(posedge CLK);
            check_equal("scl", int'(scl), 1);
        end
    endtask

    task automatic read_unwritten();
        read_check(11'h3c5, 8'hc5 ^ 8'h5a);
        read_check(11'h7ff, 8'hff ^ 8'h5a);
    endtask

    task automatic write_and_readback();
        write_byte(11'h155, 8'ha7);
        read_check(11'h155, 8'ha7);
    endtask

    // each block select once and the neighbors of each write
    task automatic sweep_banks();
        eeprom_pkg::ee_addr_t a [8];
        eeprom_pkg::ee_addr_t lo;
        eeprom_pkg::ee_addr_t hi;
        eeprom_pkg::ee_addr_t other;
        for (int b = 0; b < 8; b++)
        begin
            a[b]  = {3'(b), 8'($urandom)};
            lo    = a[b] - 11'd1;
            hi    = a[b] + 11'd1;
            other = a[b] ^ 11'h700;     // same low byte in another bank
            write_byte(a[b], 8'($urandom));
            read_check(lo, shadow[lo]);
            read_check(hi, shadow[hi]);
            read_check(other, shadow[other]);
        end
        for (int b = 0; b < 8; b++)
            read_check(a[b], shadow[a[b]]);
    endtask

    task automatic strobes_while_busy();
        int acks0;
        @(posedge CLK);
        acks0 = acks;
        wr    <= 1'b1;
        addr  <= 11'h6a3;
        wdata <= 8'h3c;
        @(posedge CLK);
        wr <= 1'b0;
        repeat (6) @(posedge CLK);
        wr    <= 1'b1;      // both strobes while busy
        rd    <= 1'b1;
        addr  <= 11'h6a4;
        wdata <= 8'hc3;
        repeat (3) @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
        wait_ack();
        shadow[11'h6a3] = 8'h3c;
        repeat (250) @(posedge CLK);    // room for a second ack that must not come
        check_equal("ack count", acks - acks0, 1);
        read_check(11'h6a3, 8'h3c);
        read_check(11'h6a4, shadow[11'h6a4]);
    endtask

    initial
    begin
        void'($urandom(32'hcb6e_a2ee));
        wr    <= 1'b0;
        rd    <= 1'b0;
        addr  <= '0;
        wdata <= '0;
        for (int i = 0; i < 2048; i++)
            shadow[i] = 8'(i) ^ 8'h5a;
        wait (RESET === 1'b0);
        @(posedge CLK);
        idle_after_reset();
        read_unwritten();
        write_and_readback();
        sweep_banks();
        strobes_while_busy();
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: design/eeprom_consts.svh
`ifndef EEPROM_CONSTS_SVH
`define EEPROM_CONSTS_SVH

// CLK cycles per half SCL period
// must be even, SDA moves at the middle of a half period
`define EE_SCL_HALF 2

// fixed upper nibble of the control byte
`define EE_DEV_CODE 4'b1010

// 2K byte array
`define EE_ADDR_W 11

// one data or control byte
`define EE_DATA_W 8

`endif

// File: design/eeprom_ctrl_top.sv
`timescale 1ns/1ps

module eeprom_ctrl_top
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 wr,
    input  logic                 rd,
    input  eeprom_pkg::ee_addr_t addr,
    input  eeprom_pkg::ee_byte_t wdata,
    output logic                 ack,
    output eeprom_pkg::ee_byte_t rdata,
    output logic                 scl,
    output logic                 sda_out,
    output logic                 sda_oe,
    input  logic                 sda_in
);

    eeprom_pkg::bit_cmd_t cmd;
    logic                 cmd_valid;
    eeprom_pkg::ee_byte_t tx_byte;
    logic                 done;
    eeprom_pkg::ee_byte_t rx_byte;

    eeprom_sequencer u_seq
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wdata     (wdata),
        .ack       (ack),
        .rdata     (rdata),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .tx_byte   (tx_byte),
        .done      (done),
        .rx_byte   (rx_byte)
    );

    // wire side, SDA split into out, enable and in
    serial_bit_engine u_eng
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .tx_byte   (tx_byte),
        .done      (done),
        .rx_byte   (rx_byte),
        .scl       (scl),
        .sda_out   (sda_out),
        .sda_oe    (sda_oe),
        .sda_in    (sda_in)
    );

endmodule

// File: design/eeprom_pkg.sv
`include "eeprom_consts.svh"

package eeprom_pkg;

    typedef logic [`EE_ADDR_W-1:0] ee_addr_t;
    typedef logic [`EE_DATA_W-1:0] ee_byte_t;

    // commands accepted by the bit engine
    typedef enum logic [2:0]
    {
        cmd_start,
        cmd_send,
        cmd_recv,
        cmd_stop
    } bit_cmd_t;

    typedef enum logic [3:0]
    {
        st_idle,
        st_wr_start,    // first start, write direction
        st_ctrl_w,
        st_addr,
        st_data_w,
        st_rd_start,    // repeated start
        st_ctrl_r,
        st_data_r,
        st_stop,
        st_ack
    } seq_state_t;

endpackage

// File: design/eeprom_sequencer.sv
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module eeprom_sequencer
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 wr,
    input  logic                 rd,
    input  eeprom_pkg::ee_addr_t addr,
    input  eeprom_pkg::ee_byte_t wdata,
    output logic                 ack,
    output eeprom_pkg::ee_byte_t rdata,
    output eeprom_pkg::bit_cmd_t cmd,
    output logic                 cmd_valid,
    output eeprom_pkg::ee_byte_t tx_byte,
    input  logic                 done,
    input  eeprom_pkg::ee_byte_t rx_byte
);

    eeprom_pkg::seq_state_t state;
    eeprom_pkg::seq_state_t step_to;
    eeprom_pkg::ee_addr_t   addr_r;
    eeprom_pkg::ee_byte_t   wdata_r;
    eeprom_pkg::ee_byte_t   ctrl_w;
    eeprom_pkg::ee_byte_t   ctrl_r;
    logic                   is_rd;
    logic                   take;

    // strobes outside idle are dropped, wr wins over rd
    assign take = (state == eeprom_pkg::st_idle) && (wr || rd);

    // device code, block select, R/W
    assign ctrl_w = {`EE_DEV_CODE, addr_r[`EE_ADDR_W-1:8], 1'b0};
    assign ctrl_r = {`EE_DEV_CODE, addr_r[`EE_ADDR_W-1:8], 1'b1};

    assign ack = (state == eeprom_pkg::st_ack);

    // command for the state just entered, valid with the cmd_valid pulse
    always_comb
    begin
        cmd     = eeprom_pkg::cmd_stop;
        tx_byte = '0;
        case (state)
            eeprom_pkg::st_wr_start,
            eeprom_pkg::st_rd_start:
                cmd = eeprom_pkg::cmd_start;
            eeprom_pkg::st_ctrl_w:
            begin
                cmd     = eeprom_pkg::cmd_send;
                tx_byte = ctrl_w;
            end
            eeprom_pkg::st_addr:
            begin
                cmd     = eeprom_pkg::cmd_send;
                tx_byte = addr_r[7:0];
            end
            eeprom_pkg::st_data_w:
            begin
                cmd     = eeprom_pkg::cmd_send;
                tx_byte = wdata_r;
            end
            eeprom_pkg::st_ctrl_r:
            begin
                cmd     = eeprom_pkg::cmd_send;
                tx_byte = ctrl_r;
            end
            eeprom_pkg::st_data_r:
                cmd = eeprom_pkg::cmd_recv;
            default:
                cmd = eeprom_pkg::cmd_stop;
        endcase
    end

    // where each done leads
    always_comb
    begin
        case (state)
            eeprom_pkg::st_wr_start: step_to = eeprom_pkg::st_ctrl_w;
            eeprom_pkg::st_ctrl_w:   step_to = eeprom_pkg::st_addr;
            eeprom_pkg::st_addr:     step_to = is_rd ? eeprom_pkg::st_rd_start
                                                     : eeprom_pkg::st_data_w;
            eeprom_pkg::st_data_w:   step_to = eeprom_pkg::st_stop;
            eeprom_pkg::st_rd_start: step_to = eeprom_pkg::st_ctrl_r;
            eeprom_pkg::st_ctrl_r:   step_to = eeprom_pkg::st_data_r;
            eeprom_pkg::st_data_r:   step_to = eeprom_pkg::st_stop;
            eeprom_pkg::st_stop:     step_to = eeprom_pkg::st_ack;
            default:                 step_to = eeprom_pkg::st_idle;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= eeprom_pkg::st_idle;
            cmd_valid <= 1'b0;
            is_rd     <= 1'b0;
        end
        else
        begin
            cmd_valid <= 1'b0;
            if (take)
            begin
                is_rd     <= !wr;
                state     <= eeprom_pkg::st_wr_start;
                cmd_valid <= 1'b1;
            end
            else if (state == eeprom_pkg::st_ack)
                state <= eeprom_pkg::st_idle;
            else if (state != eeprom_pkg::st_idle && done)
            begin
                state     <= step_to;
                cmd_valid <= (step_to != eeprom_pkg::st_ack);   // stop is the last command
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (take)
        begin
            addr_r  <= addr;
            wdata_r <= wdata;
        end
        if (state == eeprom_pkg::st_stop && done && is_rd)
            rdata <= rx_byte;   // held until the next read ends
    end

    a_ack_single : assert property (@(posedge CLK) disable iff (RESET)
        ack |=> (!ack && state == eeprom_pkg::st_idle))
        else $error("ack longer than one cycle");

endmodule

// File: design/serial_bit_engine.sv
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module serial_bit_engine
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  eeprom_pkg::bit_cmd_t cmd,
    input  logic                 cmd_valid,
    input  eeprom_pkg::ee_byte_t tx_byte,
    output logic                 done,
    output eeprom_pkg::ee_byte_t rx_byte,
    output logic                 scl,
    output logic                 sda_out,
    output logic                 sda_oe,
    input  logic                 sda_in
);

    localparam int HALF   = `EE_SCL_HALF;
    localparam int PERIOD = 2 * HALF;
    localparam int MID    = HALF / 2;
    localparam int CNT_W  = $clog2(PERIOD);
    localparam int BIT_W  = $clog2(`EE_DATA_W);

    logic                 busy;
    logic                 accept;
    logic [CNT_W-1:0]     cnt;      // position inside one SCL period
    logic [CNT_W-1:0]     cnt_nxt;
    logic                 last_cycle;
    logic                 last_period;
    logic [BIT_W-1:0]     bit_cnt;
    eeprom_pkg::bit_cmd_t cmd_r;
    eeprom_pkg::ee_byte_t shreg;

    assign accept     = cmd_valid && !busy;
    assign last_cycle = (cnt == CNT_W'(PERIOD - 1));
    assign cnt_nxt    = last_cycle ? '0 : cnt + 1'b1;

    // start and stop are one period, bytes are eight
    always_comb
    begin
        if (cmd_r == eeprom_pkg::cmd_start || cmd_r == eeprom_pkg::cmd_stop)
            last_period = 1'b1;
        else
            last_period = (bit_cnt == BIT_W'(`EE_DATA_W - 1));
    end

    // each period is a low half then a high half, so SCL rests high when idle
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy    <= 1'b0;
            done    <= 1'b0;
            cnt     <= '0;
            bit_cnt <= '0;
            cmd_r   <= eeprom_pkg::cmd_start;
            scl     <= 1'b1;
            sda_out <= 1'b1;
            sda_oe  <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (accept)
            begin
                busy    <= 1'b1;
                cnt     <= '0;
                bit_cnt <= '0;
                cmd_r   <= cmd;
                scl     <= 1'b0;        // first low half
            end
            else if (busy)
            begin
                cnt <= cnt_nxt;
                if (cnt_nxt == CNT_W'(HALF))
                    scl <= 1'b1;

                // middle of the low half
                if (cnt_nxt == CNT_W'(MID))
                begin
                    case (cmd_r)
                        eeprom_pkg::cmd_start:
                        begin
                            sda_out <= 1'b1;    // also sets up a repeated start
                            sda_oe  <= 1'b1;
                        end
                        eeprom_pkg::cmd_stop:
                        begin
                            sda_out <= 1'b0;
                            sda_oe  <= 1'b1;
                        end
                        eeprom_pkg::cmd_send:
                        begin
                            sda_out <= shreg[`EE_DATA_W-1];  // msb first
                            sda_oe  <= 1'b1;
                        end
                        default:
                            sda_oe <= 1'b0;     // slave drives
                    endcase
                end

                // middle of the high half
                if (cnt_nxt == CNT_W'(HALF + MID))
                begin
                    if (cmd_r == eeprom_pkg::cmd_start)
                        sda_out <= 1'b0;
                    else if (cmd_r == eeprom_pkg::cmd_stop)
                        sda_out <= 1'b1;
                end

                if (last_cycle)
                begin
                    if (last_period)
                    begin
                        busy <= 1'b0;
                        done <= 1'b1;
                        if (cmd_r == eeprom_pkg::cmd_stop)
                            sda_oe <= 1'b0;     // pull-up keeps the line high
                    end
                    else
                    begin
                        scl     <= 1'b0;
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
            shreg <= tx_byte;
        else if (busy && cmd_r == eeprom_pkg::cmd_send && cnt_nxt == CNT_W'(MID))
            shreg <= {shreg[`EE_DATA_W-2:0], 1'b0};
        else if (busy && cmd_r == eeprom_pkg::cmd_recv && last_cycle)
            shreg <= {shreg[`EE_DATA_W-2:0], sda_in};   // SCL high and settled

        if (busy && cmd_r == eeprom_pkg::cmd_recv && last_cycle && last_period)
            rx_byte <= {shreg[`EE_DATA_W-2:0], sda_in};
    end

    // sequencer must wait for done
    a_cmd_when_idle : assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |-> !busy)
        else $error("cmd_valid while the bit engine is busy");

    a_rx_released : assert property (@(posedge CLK) disable iff (RESET)
        (busy && cmd_r == eeprom_pkg::cmd_recv && (bit_cnt != '0 || cnt >= CNT_W'(MID)))
        |-> !sda_oe)
        else $error("SDA driven during a receive");

    a_sda_scl_high : assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && sda_out != $past(sda_out))
        |-> ($past(cmd_r) == eeprom_pkg::cmd_start || $past(cmd_r) == eeprom_pkg::cmd_stop))
        else $error("SDA moved while SCL high outside start or stop");

endmodule

// File: flist.f
+incdir+design
design/eeprom_pkg.sv
design/serial_bit_engine.sv
design/eeprom_sequencer.sv
design/eeprom_ctrl_top.sv
bench/clock_gen.sv
bench/eeprom_model.sv
bench/tb_eeprom_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and judge the log
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module tb_eeprom_ctrl -f flist.f -o tb_sim \
    || exit 1
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "ERRORS FOUND" sim.log && exit 1
grep -q "NO ERRORS" sim.log || exit 1
exit 0
